// ==== Makefile ====
# Verilator build and run of the bus glue testbench

VERILATOR ?= verilator
TOP       ?= tb_st_bus_glue
FILELIST  ?= st_bus_glue.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/st_addr_decode.sv ====
`timescale 1ns/1ps

module st_addr_decode (
	input  st_bus_pkg::cpu_addr_t   addr,
	input  logic                    rw,
	input  st_bus_pkg::mem_size_t   mem_cfg,
	input  logic                    blitter_en, // blitter present
	output logic                    mem_hit,
	output logic                    ram_hit,
	output logic                    io_hit,
	output logic                    iack_hit,
	output st_bus_pkg::periph_t     periph,
	output st_bus_pkg::iack_level_t iack_level
);

	// base/mask compare on byte address
	function automatic logic match(
		input st_bus_pkg::byte_addr_t a,
		input st_bus_pkg::byte_addr_t base,
		input st_bus_pkg::byte_addr_t mask
	);
		match = ((a & mask) == base);
	endfunction

	st_bus_pkg::byte_addr_t byte_addr;
	logic in_ram14;
	logic size_ok;
	logic in_rom;
	logic in_io;
	logic in_iack;

	assign byte_addr = {addr, 1'b0};

	// 000000..dfffff is ram space whatever is fitted
	assign in_ram14 = (byte_addr < st_bus_pkg::ram14_top);

	// does the configured size reach this far
	always_comb begin
		if (byte_addr < st_bus_pkg::ram_4m_top)
			size_ok = 1'b1; // first 4m always mapped
		else if (byte_addr < st_bus_pkg::ram_8m_top)
			size_ok = (mem_cfg == st_bus_pkg::mem_8m) || (mem_cfg == st_bus_pkg::mem_14m);
		else
			size_ok = (mem_cfg == st_bus_pkg::mem_14m); // 8m..14m
	end

	assign ram_hit = in_ram14 && size_ok;

	// both tos images and the cartridge are read only
	assign in_rom = match(byte_addr, st_bus_pkg::tos256_base, st_bus_pkg::tos256_mask) ||
		match(byte_addr, st_bus_pkg::tos192_base, st_bus_pkg::tos192_mask) ||
		match(byte_addr, st_bus_pkg::tos192_hi_base, st_bus_pkg::tos192_hi_mask) ||
		match(byte_addr, st_bus_pkg::cart_base, st_bus_pkg::cart_mask);

	assign mem_hit = in_ram14 || (rw && in_rom); // rom writes fall through to berr

	assign in_io   = match(byte_addr, st_bus_pkg::io_base, st_bus_pkg::io_mask);
	assign in_iack = match(byte_addr, st_bus_pkg::iack_base, st_bus_pkg::iack_mask);

	// peripheral windows never overlap, so order does not matter
	always_comb begin
		periph = st_bus_pkg::periph_none;
		if (in_io) begin
			if (match(byte_addr, st_bus_pkg::mmu_base, st_bus_pkg::mmu_mask))
				periph = st_bus_pkg::periph_mmu;
			else if (match(byte_addr, st_bus_pkg::vreg_base, st_bus_pkg::vreg_mask))
				periph = st_bus_pkg::periph_vreg;
			else if (match(byte_addr, st_bus_pkg::dma_base, st_bus_pkg::dma_mask))
				periph = st_bus_pkg::periph_dma;
			else if (match(byte_addr, st_bus_pkg::psg_base, st_bus_pkg::psg_mask))
				periph = st_bus_pkg::periph_psg;
			else if (blitter_en &&
				match(byte_addr, st_bus_pkg::blitter_base, st_bus_pkg::blitter_mask))
				periph = st_bus_pkg::periph_blitter; // absent blitter -> berr, tos probes this
			else if (match(byte_addr, st_bus_pkg::mfp_base, st_bus_pkg::mfp_mask))
				periph = st_bus_pkg::periph_mfp;
			else if (match(byte_addr, st_bus_pkg::acia_base, st_bus_pkg::acia_mask))
				periph = st_bus_pkg::periph_acia;
		end
	end

	assign io_hit = in_io && (periph != st_bus_pkg::periph_none);

	// level sits in a3..a1 during an acknowledge
	always_comb begin
		iack_level = st_bus_pkg::ack_other;
		if (in_iack) begin
			case (addr[3:1])
				3'd2: iack_level = st_bus_pkg::ack_hbi;
				3'd4: iack_level = st_bus_pkg::ack_vbi;
				3'd6: iack_level = st_bus_pkg::ack_mfp;
				default: iack_level = st_bus_pkg::ack_other;
			endcase
		end
	end

	assign iack_hit = in_iack && (iack_level != st_bus_pkg::ack_other); // other levels time out

endmodule

// ==== design/st_bus_glue.sv ====
`timescale 1ns/1ps

module st_bus_glue (
	input  logic                  clk_8,
	input  logic                  pll_locked,
	input  st_bus_pkg::cpu_addr_t addr,
	input  logic                  as_n,
	input  logic                  rw,        // 1 = read
	input  logic                  br,        // other master wants the bus
	input  st_bus_pkg::mem_size_t mem_cfg,
	input  logic                  blitter_en,
	input  logic                  clr_berr,
	input  logic                  mfp_irq,
	input  logic                  st_hs,
	input  logic                  st_vs,
	output logic                  dtack_n,
	output logic                  berr,
	output logic                  ram_rd,
	output logic                  ram_wr,
	output logic                  io_strobe,
	output st_bus_pkg::periph_t   periph,
	output logic                  mfp_iack,
	output st_bus_pkg::cpu_data_t vec_data,
	output st_bus_pkg::ipl_t      ipl
);

	// decode results
	logic mem_hit;
	logic ram_hit;
	logic io_hit;
	logic iack_hit;
	st_bus_pkg::iack_level_t iack_level;

	logic iack_cycle; // one clk, qualified by the strobe

	st_addr_decode u_decode (
		.addr       (addr),
		.rw         (rw),
		.mem_cfg    (mem_cfg),
		.blitter_en (blitter_en),
		.mem_hit    (mem_hit),
		.ram_hit    (ram_hit),
		.io_hit     (io_hit),
		.iack_hit   (iack_hit),
		.periph     (periph),
		.iack_level (iack_level)
	);

	st_dtack_ctrl u_dtack (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.as_n       (as_n),
		.rw         (rw),
		.br         (br),
		.clr_berr   (clr_berr),
		.mem_hit    (mem_hit),
		.ram_hit    (ram_hit),
		.io_hit     (io_hit),
		.iack_hit   (iack_hit),
		.dtack_n    (dtack_n),
		.berr       (berr),
		.ram_rd     (ram_rd),
		.ram_wr     (ram_wr),
		.io_strobe  (io_strobe),
		.iack_cycle (iack_cycle)
	);

	st_irq_ctrl u_irq (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.st_hs      (st_hs),
		.st_vs      (st_vs),
		.mfp_irq    (mfp_irq),
		.iack_cycle (iack_cycle),
		.iack_level (iack_level),
		.ipl        (ipl),
		.vec_data   (vec_data),
		.mfp_iack   (mfp_iack)
	);

endmodule

// ==== design/st_bus_pkg.sv ====
package st_bus_pkg;

	// cpu side types
	typedef logic [23:1] cpu_addr_t; // word address, a0 stays inside the cpu
	typedef logic [7:0]  cpu_data_t; // vector byte on d7..d0
	typedef logic [23:0] byte_addr_t;

	// memory size switch, same codes as the core config word
	typedef enum logic [2:0] {
		mem_512k = 3'd0,
		mem_1m   = 3'd1,
		mem_2m   = 3'd2,
		mem_4m   = 3'd3,
		mem_8m   = 3'd4,
		mem_14m  = 3'd5
	} mem_size_t;

	typedef enum logic [2:0] {
		periph_none,
		periph_mmu,
		periph_vreg,
		periph_mfp,
		periph_acia,
		periph_psg,
		periph_dma,
		periph_blitter
	} periph_t;

	// four clk_8 slots per bus cycle
	typedef enum logic [1:0] {
		phase_video   = 2'd0,
		phase_cpu     = 2'd1,
		phase_spare_a = 2'd2,
		phase_spare_b = 2'd3
	} bus_phase_t;

	// active low, ipl0 is always high on the st
	typedef enum logic [2:0] {
		ipl_none = 3'b111,
		ipl_hbi  = 3'b101, // level 2
		ipl_vbi  = 3'b011, // level 4
		ipl_mfp  = 3'b001  // level 6
	} ipl_t;

	typedef enum logic [2:0] {
		ack_other = 3'd0,
		ack_hbi   = 3'd2,
		ack_vbi   = 3'd4,
		ack_mfp   = 3'd6
	} iack_level_t;

	localparam logic [2:0] berr_limit = 3'd7; // cpu slots without dtack
	localparam cpu_data_t  vec_vbi    = 8'h1c;
	localparam cpu_data_t  vec_hbi    = 8'h1a;

	// ram limits, byte addresses
	localparam byte_addr_t ram_4m_top  = 24'h400000;
	localparam byte_addr_t ram_8m_top  = 24'h800000;
	localparam byte_addr_t ram14_top   = 24'he00000;

	// rom and cartridge
	localparam byte_addr_t tos256_base    = 24'he00000;
	localparam byte_addr_t tos256_mask    = 24'hfc0000;
	localparam byte_addr_t tos192_base    = 24'hfc0000; // fc0000..fdffff
	localparam byte_addr_t tos192_mask    = 24'hfe0000;
	localparam byte_addr_t tos192_hi_base = 24'hfe0000; // fe0000..feffff
	localparam byte_addr_t tos192_hi_mask = 24'hff0000;
	localparam byte_addr_t cart_base      = 24'hfa0000;
	localparam byte_addr_t cart_mask      = 24'hfe0000;

	// io page and the peripherals in it
	localparam byte_addr_t io_base      = 24'hff0000;
	localparam byte_addr_t io_mask      = 24'hff0000;
	localparam byte_addr_t mmu_base     = 24'hff8000;
	localparam byte_addr_t mmu_mask     = 24'hfffffe;
	localparam byte_addr_t vreg_base    = 24'hff8200;
	localparam byte_addr_t vreg_mask    = 24'hffff80;
	localparam byte_addr_t dma_base     = 24'hff8600;
	localparam byte_addr_t dma_mask     = 24'hfffff0;
	localparam byte_addr_t psg_base     = 24'hff8800;
	localparam byte_addr_t psg_mask     = 24'hffff00;
	localparam byte_addr_t blitter_base = 24'hff8a00;
	localparam byte_addr_t blitter_mask = 24'hffff00;
	localparam byte_addr_t mfp_base     = 24'hfffa00;
	localparam byte_addr_t mfp_mask     = 24'hffffc0;
	localparam byte_addr_t acia_base    = 24'hfffc00;
	localparam byte_addr_t acia_mask    = 24'hffff00;
	localparam byte_addr_t iack_base    = 24'hfffff0; // level in a3..a1
	localparam byte_addr_t iack_mask    = 24'hfffff0;

endpackage

// ==== design/st_dtack_ctrl.sv ====
`timescale 1ns/1ps

module st_dtack_ctrl (
	input  logic clk_8,
	input  logic pll_locked,
	input  logic as_n,
	input  logic rw,
	input  logic br,
	input  logic clr_berr,
	input  logic mem_hit,
	input  logic ram_hit,
	input  logic io_hit,
	input  logic iack_hit,
	output logic dtack_n,
	output logic berr,
	output logic ram_rd,
	output logic ram_wr,
	output logic io_strobe,
	output logic iack_cycle
);

	st_bus_pkg::bus_phase_t phase;
	logic       strobe;  // registered as, valid in the cpu slot only
	logic       grant;   // strobe and nobody else owns the bus
	logic [2:0] timeout; // cpu slots waited without dtack

	// slot counter, video slot first after reset
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			phase <= st_bus_pkg::phase_video;
		else
			phase <= st_bus_pkg::bus_phase_t'(phase + 2'd1);
	end

	// sample as on the video slot edge -> high for the cpu slot
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			strobe <= 1'b0;
		else
			strobe <= (phase == st_bus_pkg::phase_video) && !as_n && !br;
	end

	assign grant = strobe && !br; // br holds the cpu off, it just retries

	assign dtack_n    = !(grant && (mem_hit || io_hit || iack_hit));
	assign ram_rd     = grant && rw && mem_hit;
	assign ram_wr     = grant && !rw && ram_hit; // no write outside fitted ram
	assign io_strobe  = grant && io_hit;
	assign iack_cycle = grant && iack_hit;

	// bus error timeout, only looked at in cpu slots
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			timeout <= '0;
		end else if (phase == st_bus_pkg::phase_cpu) begin
			if (timeout != st_bus_pkg::berr_limit) begin
				if (as_n || br || !dtack_n)
					timeout <= '0; // idle, stalled by br, or answered
				else
					timeout <= timeout + 3'd1;
			end else if (clr_berr) begin
				timeout <= '0; // cpu has taken the exception
			end
		end
	end

	assign berr = (timeout == st_bus_pkg::berr_limit); // held until cleared

endmodule

// ==== design/st_irq_ctrl.sv ====
`timescale 1ns/1ps

module st_irq_ctrl (
	input  logic                    clk_8,
	input  logic                    pll_locked,
	input  logic                    st_hs,
	input  logic                    st_vs,
	input  logic                    mfp_irq,
	input  logic                    iack_cycle,
	input  st_bus_pkg::iack_level_t iack_level,
	output st_bus_pkg::ipl_t        ipl,
	output st_bus_pkg::cpu_data_t   vec_data,
	output logic                    mfp_iack
);

	// bit 1 = vbi from st_vs, bit 0 = hbi from st_hs
	logic [1:0] sync_a;
	logic [1:0] sync_b;
	logic [1:0] sync_d; // previous synced level
	logic [1:0] rise;
	logic [1:0] ack_clr;
	logic [1:0] req;    // pending vbi / hbi
	logic       ack_vbi;
	logic       ack_hbi;

	// sync comes from the video clock domain
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			sync_a <= '0;
			sync_b <= '0;
			sync_d <= '0;
		end else begin
			sync_a <= {st_vs, st_hs};
			sync_b <= sync_a;
			sync_d <= sync_b;
		end
	end

	assign rise = sync_b & ~sync_d; // one clk per rising edge

	assign ack_vbi = iack_cycle && (iack_level == st_bus_pkg::ack_vbi);
	assign ack_hbi = iack_cycle && (iack_level == st_bus_pkg::ack_hbi);
	assign ack_clr = {ack_vbi, ack_hbi};

	// acknowledge wins over a new edge in the same clk
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			req <= '0;
		else
			req <= (req | rise) & ~ack_clr;
	end

	// priority mfp, vbi, hbi
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			ipl <= st_bus_pkg::ipl_none;
		else if (mfp_irq)
			ipl <= st_bus_pkg::ipl_mfp;
		else if (req[1])
			ipl <= st_bus_pkg::ipl_vbi;
		else if (req[0])
			ipl <= st_bus_pkg::ipl_hbi;
		else
			ipl <= st_bus_pkg::ipl_none;
	end

	// cpu runs vectored, so the st autovector levels get a byte from here
	always_comb begin
		if (ack_vbi)
			vec_data = st_bus_pkg::vec_vbi;
		else if (ack_hbi)
			vec_data = st_bus_pkg::vec_hbi;
		else
			vec_data = '0; // mfp supplies its own vector
	end

	assign mfp_iack = iack_cycle && (iack_level == st_bus_pkg::ack_mfp);

endmodule

// ==== st_bus_glue.f ====
design/st_bus_pkg.sv
design/st_addr_decode.sv
design/st_dtack_ctrl.sv
design/st_irq_ctrl.sv
design/st_bus_glue.sv
verif/st_clk_gen.sv
verif/st_bus_glue_props.sv
verif/tb_st_bus_glue.sv

// ==== verif/st_bus_glue_props.sv ====
`timescale 1ns/1ps

module st_bus_glue_props (
	input logic                   clk_8,
	input logic                   pll_locked,
	input st_bus_pkg::bus_phase_t phase,
	input logic                   strobe,
	input logic                   br,
	input logic                   dtack_n,
	input logic                   berr,
	input logic                   clr_berr
);

	// registered strobe lives in the cpu slot only
	strobe_in_cpu_slot: assert property (@(posedge clk_8) disable iff (!pll_locked)
		strobe |-> (phase == st_bus_pkg::phase_cpu))
		else $error("strobe high outside the cpu slot");

	// another master on the bus, so no dtack
	br_blocks_dtack: assert property (@(posedge clk_8) disable iff (!pll_locked)
		br |-> dtack_n)
		else $error("dtack_n low while br is high");

	berr_held: assert property (@(posedge clk_8) disable iff (!pll_locked)
		(berr && !clr_berr) |=> berr) // only the cpu may clear it
		else $error("berr dropped without clr_berr");

endmodule

bind st_dtack_ctrl st_bus_glue_props u_props (
	.clk_8      (clk_8),
	.pll_locked (pll_locked),
	.phase      (phase),
	.strobe     (strobe),
	.br         (br),
	.dtack_n    (dtack_n),
	.berr       (berr),
	.clr_berr   (clr_berr)
);

// ==== verif/st_clk_gen.sv ====
`timescale 1ns/1ps

module st_clk_gen (
	output logic clk_8,
	output logic pll_locked
);

	initial begin
		clk_8 = 1'b0;
		forever #20 clk_8 = ~clk_8; // 40 ns period
	end

	// lock comes 5 clocks in, released away from the rising edge
	initial begin
		pll_locked = 1'b0;
		repeat (5) @(posedge clk_8);
		@(negedge clk_8);
		pll_locked = 1'b1;
	end

endmodule

// ==== verif/tb_st_bus_glue.sv ====
`timescale 1ns/1ps

module tb_st_bus_glue;

	// expected decode of one access
	typedef struct packed {
		logic                  mem;
		logic                  ram;
		logic                  io;
		logic                  iack;
		st_bus_pkg::periph_t   periph;
		logic [2:0]            level;
		st_bus_pkg::cpu_data_t vec;
	} expect_t;

	// region starts for the random reads including holes
	localparam logic [23:0] region_bases [0:16] = '{
		24'h000000, 24'h3ff000, 24'h500000, 24'h900000, 24'he00000, 24'hf00000,
		24'hfa0000, 24'hfc0000, 24'hfe0000, 24'hff8000, 24'hff8200, 24'hff8600,
		24'hff8800, 24'hff8a00, 24'hff9000, 24'hfffa00, 24'hfffc00};

	logic clk_8;
	logic pll_locked;
	st_bus_pkg::cpu_addr_t addr;
	logic as_n;
	logic rw;
	logic br;
	logic blitter_en;
	logic clr_berr;
	logic mfp_irq;
	logic st_hs;
	logic st_vs;
	st_bus_pkg::mem_size_t mem_cfg;
	logic dtack_n;
	logic berr;
	logic ram_rd;
	logic ram_wr;
	logic io_strobe;
	logic mfp_iack;
	st_bus_pkg::periph_t periph;
	st_bus_pkg::cpu_data_t vec_data;
	st_bus_pkg::ipl_t ipl;

	int errors;
	int test_errors; // errors before the current test
	int tests_run;
	int tests_failed;
	logic last_wr;   // captured on the dtack cycle
	logic last_iack;
	st_bus_pkg::cpu_data_t last_vec;
	expect_t exp_now;
	logic [1:0] slot;   // bus slot, 0 is the video slot
	logic strobe_ref;   // strobe as the bus timing places it
	logic ack_now;      // expected dtack this cycle

	st_clk_gen u_clk (.clk_8(clk_8), .pll_locked(pll_locked));

	st_bus_glue dut (.*);

	function automatic expect_t ref_decode(input st_bus_pkg::cpu_addr_t a, input logic rd,
		input st_bus_pkg::mem_size_t cfg, input logic blt);
		expect_t e;
		logic [23:0] b;
		logic big;
		logic rom;
		b = {a, 1'b0};
		e = '0;
		big = (cfg == st_bus_pkg::mem_8m) || (cfg == st_bus_pkg::mem_14m);
		e.ram = (b < 24'h400000) || (b < 24'h800000 && big) ||
			(b < 24'he00000 && cfg == st_bus_pkg::mem_14m);
		rom = (b >= 24'he00000 && b < 24'he40000) || (b >= 24'hfa0000 && b < 24'hff0000);
		e.mem = (b < 24'he00000) || (rd && rom); // tos 192k and cartridge are contiguous
		if (b >= 24'hff8000 && b <= 24'hff8001)
			e.periph = st_bus_pkg::periph_mmu;
		else if (b >= 24'hff8200 && b <= 24'hff827f)
			e.periph = st_bus_pkg::periph_vreg;
		else if (b >= 24'hff8600 && b <= 24'hff860f)
			e.periph = st_bus_pkg::periph_dma;
		else if (b[23:8] == 16'hff88)
			e.periph = st_bus_pkg::periph_psg;
		else if (b[23:8] == 16'hff8a && blt)
			e.periph = st_bus_pkg::periph_blitter;
		else if (b >= 24'hfffa00 && b <= 24'hfffa3f)
			e.periph = st_bus_pkg::periph_mfp;
		else if (b[23:8] == 16'hfffc)
			e.periph = st_bus_pkg::periph_acia;
		e.io = (e.periph != st_bus_pkg::periph_none);
		e.level = a[3:1];
		e.iack = (b >= 24'hfffff0) && (e.level == 3'd2 || e.level == 3'd4 || e.level == 3'd6);
		if (e.iack && e.level == 3'd4)
			e.vec = 8'h1c;
		else if (e.iack && e.level == 3'd2)
			e.vec = 8'h1a;
		return e;
	endfunction

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("Error %s got %h expected %h", name, got, want);
		errors++;
	endtask

	task automatic note_fail(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	// four slots per bus cycle, strobe taken in the video slot
	always @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			slot <= 2'd0;
			strobe_ref <= 1'b0;
		end else begin
			slot <= slot + 2'd1;
			strobe_ref <= (slot == 2'd0) && !as_n && !br;
		end
	end

	// decode and strobes checked at every falling edge
	always @(negedge clk_8) begin
		if (pll_locked) begin
			exp_now = ref_decode(addr, rw, mem_cfg, blitter_en);
			ack_now = strobe_ref && !br && (exp_now.mem || exp_now.io || exp_now.iack);
			assert (periph == exp_now.periph)
				else report_value("periph", 32'(periph), 32'(exp_now.periph));
			assert (dtack_n == !ack_now)
				else report_value("dtack_n", 32'(dtack_n), 32'(!ack_now));
			assert (ram_rd == (ack_now && rw && exp_now.mem))
				else report_value("ram_rd", 32'(ram_rd), 32'(ack_now && rw && exp_now.mem));
			assert (ram_wr == (ack_now && !rw && exp_now.ram))
				else report_value("ram_wr", 32'(ram_wr), 32'(ack_now && !rw && exp_now.ram));
			assert (io_strobe == (ack_now && exp_now.io))
				else report_value("io_strobe", 32'(io_strobe), 32'(ack_now && exp_now.io));
			assert (mfp_iack == (ack_now && exp_now.iack && exp_now.level == 3'd6))
				else report_value("mfp_iack", 32'(mfp_iack),
					32'(ack_now && exp_now.iack && exp_now.level == 3'd6));
			assert (vec_data == (ack_now ? exp_now.vec : 8'h00))
				else report_value("vec_data", 32'(vec_data), 32'(ack_now ? exp_now.vec : 8'h00));
		end
	end

	task automatic start_cycle(input logic [23:0] b, input logic rd);
		@(posedge clk_8);
		addr <= b[23:1];
		rw <= rd;
		as_n <= 1'b0;
	endtask

	// wait for dtack or berr whichever comes first
	task automatic wait_bus(input int limit, output logic acked, output logic faulted);
		int n;
		acked = 1'b0;
		faulted = 1'b0;
		for (n = 0; n < limit && !acked && !faulted; n++) begin
			@(negedge clk_8);
			acked = !dtack_n;
			faulted = berr;
		end
		if (acked) begin
			last_wr = ram_wr;
			last_vec = vec_data;
			last_iack = mfp_iack;
		end
	endtask

	task automatic end_cycle;
		@(posedge clk_8);
		as_n <= 1'b1;
	endtask

	task automatic clear_berr;
		int n;
		logic cleared;
		cleared = 1'b0;
		@(posedge clk_8);
		clr_berr <= 1'b1;
		for (n = 0; n < 8 && !cleared; n++) begin
			@(negedge clk_8);
			cleared = !berr;
		end
		@(posedge clk_8);
		clr_berr <= 1'b0;
		assert (cleared) else note_fail("berr did not drop with clr_berr");
	endtask

	// one cpu access checked against the reference
	task automatic access(input logic [23:0] b, input logic rd);
		expect_t e;
		logic acked;
		logic faulted;
		start_cycle(b, rd);
		wait_bus(40, acked, faulted);
		e = ref_decode(b[23:1], rd, mem_cfg, blitter_en);
		end_cycle();
		if (e.mem || e.io || e.iack) begin
			assert (acked) else note_fail($sformatf("no DTACK for access at %h", b));
			if (acked && !rd)
				assert (last_wr == e.ram) else report_value("ram_wr", 32'(last_wr), 32'(e.ram));
		end else begin
			assert (faulted && !acked) else note_fail($sformatf("no bus error at %h", b));
		end
		if (faulted)
			clear_berr();
	endtask

	task automatic wait_ipl(input st_bus_pkg::ipl_t want);
		int n;
		logic seen;
		seen = 1'b0;
		for (n = 0; n < 12 && !seen; n++) begin
			@(negedge clk_8);
			seen = (ipl == want);
		end
		assert (seen) else report_value("ipl", 32'(ipl), 32'(want));
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_errors) begin
			$display("test %s ok", name);
		end else begin
			$display("test %s failed with %0d errors", name, errors - test_errors);
			tests_failed++;
		end
		test_errors = errors;
	endtask

	initial begin
		int i;
		logic acked;
		logic faulted;
		void'($urandom(6)); // one seed for the whole run
		addr = '0;
		as_n = 1'b1;
		rw = 1'b1;
		br = 1'b0;
		mem_cfg = st_bus_pkg::mem_14m;
		blitter_en = 1'b0;
		clr_berr = 1'b0;
		mfp_irq = 1'b0;
		st_hs = 1'b0;
		st_vs = 1'b0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		for (i = 0; i < 20 && !pll_locked; i++)
			@(posedge clk_8);
		if (!pll_locked)
			note_fail("pll_locked never went high");

		// random reads with and without the blitter
		for (i = 0; i < 24; i++) begin
			@(posedge clk_8);
			blitter_en <= 1'($urandom);
			access(region_bases[$urandom_range(0, 16)] | (24'($urandom) & 24'h0000fe), 1'b1);
		end
		end_test("random reads");

		// ram writes beyond 4m under every size
		for (i = 0; i < 6; i++) begin
			@(posedge clk_8);
			mem_cfg <= st_bus_pkg::mem_size_t'(i[2:0]);
			access(24'h500000, 1'b0);
			access(24'h900000, 1'b0);
		end
		end_test("memory size");

		access(24'he00000, 1'b0); // rom write gets berr and a clear
		access(24'h001000, 1'b1);
		end_test("bus error");

		@(posedge clk_8);
		br <= 1'b1;
		start_cycle(24'h002000, 1'b1);
		wait_bus(16, acked, faulted);
		assert (!acked && !faulted) else note_fail("bus cycle ended while br was held");
		@(posedge clk_8);
		br <= 1'b0;
		wait_bus(40, acked, faulted);
		end_cycle();
		assert (acked) else note_fail("read did not complete after br release");
		end_test("bus request");

		@(posedge clk_8);
		st_vs <= 1'b1;
		repeat (4) @(posedge clk_8);
		st_vs <= 1'b0;
		wait_ipl(st_bus_pkg::ipl_vbi);
		st_hs <= 1'b1; // hbi pending under vbi
		repeat (4) @(posedge clk_8);
		st_hs <= 1'b0;
		for (i = 0; i < 10; i++) begin
			@(negedge clk_8);
			assert (ipl == st_bus_pkg::ipl_vbi)
				else report_value("ipl", 32'(ipl), 32'(st_bus_pkg::ipl_vbi));
		end
		@(posedge clk_8);
		mfp_irq <= 1'b1;
		wait_ipl(st_bus_pkg::ipl_mfp);
		access(24'hfffffc, 1'b1); // level 6
		assert (last_iack) else report_value("mfp_iack", 32'(last_iack), 32'd1);
		@(posedge clk_8);
		mfp_irq <= 1'b0; // mfp drops its request once served
		wait_ipl(st_bus_pkg::ipl_vbi);
		access(24'hfffff8, 1'b1); // level 4
		assert (last_vec == 8'h1c) else report_value("vec_data", 32'(last_vec), 32'h1c);
		wait_ipl(st_bus_pkg::ipl_hbi);
		access(24'hfffff4, 1'b1); // level 2
		assert (last_vec == 8'h1a) else report_value("vec_data", 32'(last_vec), 32'h1a);
		wait_ipl(st_bus_pkg::ipl_none);
		end_test("interrupts");

		$display("tests %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
